// File: tile_mem_hub.f
logic/tile_pkg.sv
logic/proc_mem_port.sv
logic/noc_write_port.sv
logic/data_ram.sv
logic/egress_arbiter.sv
logic/tile_mem_hub.sv
testbench/tb_tile_mem_hub.sv

// File: testbench/tb_tile_mem_hub.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tile_mem_hub;

  localparam int offset_sz  = tile_pkg::default_offset_sz;
  localparam int xy_sz      = tile_pkg::default_xy_sz;
  localparam int depth      = 2 ** offset_sz;
  localparam int max_cycles = 3000;

  logic               clk_line;
  logic               clk_line_rst_low;
  logic [2*xy_sz-1:0] tile_id;
  logic               wb_cyc, wb_stb, wb_we, wb_ack, wb_err;
  tile_pkg::word_t    wb_adr, wb_dat_w, wb_dat_r;
  tile_pkg::keep_t    wb_sel;
  logic               noc_in_valid, noc_in_last, noc_in_ready;
  tile_pkg::word_t    noc_in_data;
  logic               fetch_valid, fetch_last, fetch_ready;
  logic               queue_valid, queue_last, queue_ready;
  tile_pkg::word_t    fetch_data, queue_data, noc_out_data;
  tile_pkg::keep_t    fetch_keep, queue_keep, noc_out_keep;
  logic               noc_out_valid, noc_out_last, noc_out_ready;

  int                 errors;
  int                 tests;
  int                 cycles = 0;
  int                 ready_mode;       // 0 low, 1 high, 2 random
  int unsigned        seed = 32'h1d5c_6e35;
  tile_pkg::word_t    model [depth];    // Scoreboard copy of data memory
  int                 mesh_idx [$];     // Indices written by mesh packets
  tile_pkg::word_t    out_data [$];     // Beats seen on the mesh output
  logic               out_last [$];
  tile_pkg::keep_t    out_keep [$];
  int                 pkt_tags [$];

  tile_mem_hub #(
    .offset_sz (offset_sz),
    .xy_sz     (xy_sz)
  ) dut (.*);

  initial begin
    clk_line = 1'b0;
    forever #2 clk_line = ~clk_line;
  end

  always @(posedge clk_line) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Errors found");
      $finish;
    end
  end

  // Mesh ready pattern changes just after each rising edge
  always @(posedge clk_line) begin
    #1;
    if (ready_mode == 2) noc_out_ready = $urandom % 2;
    else noc_out_ready = (ready_mode == 1);
  end

  // ********************
  // Egress monitor
  // ********************
  always @(negedge clk_line) begin
    if (clk_line_rst_low === 1'b1) begin
      if (fetch_ready && queue_ready) report_fail("both sources see ready");
      if (fetch_ready && noc_out_data !== fetch_data) report_fail("fetch not steered out");
      if (queue_ready && noc_out_data !== queue_data) report_fail("queue not steered out");
      if (noc_out_valid && noc_out_ready) begin
        out_data.push_back(noc_out_data);
        out_last.push_back(noc_out_last);
        out_keep.push_back(noc_out_keep);
      end
    end
  end

  task automatic report_fail(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    errors++;
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("Test %s finished, %0d errors so far", name, errors);
  endtask

  // Byte address for a word index on a given tile
  function automatic tile_pkg::word_t addr_of(input logic [2*xy_sz-1:0] tile, input int index);
    tile_pkg::word_t adr;
    adr = '0;
    adr[2 +: offset_sz] = index[offset_sz-1:0];
    adr[2+offset_sz +: 2*xy_sz] = tile;
    return adr;
  endfunction

  function automatic bit outputs_low();
    return !wb_ack && !wb_err && !noc_out_valid && !fetch_ready && !queue_ready;
  endfunction

  // One Wishbone classic transfer that returns just after the response edge
  task automatic wb_xfer(input logic we, input tile_pkg::word_t adr, input tile_pkg::keep_t sel,
                         input tile_pkg::word_t dat, output logic ack, output logic err,
                         output tile_pkg::word_t rdata);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_sel   = sel;
    wb_dat_w = dat;
    do begin
      @(posedge clk_line);
      #1;
    end while (!(wb_ack || wb_err));
    ack    = wb_ack;
    err    = wb_err;
    rdata  = wb_dat_r;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
  endtask

  task automatic local_write(input int index, input tile_pkg::keep_t sel,
                             input tile_pkg::word_t dat);
    logic            ack;
    logic            err;
    tile_pkg::word_t rd;
    tile_pkg::word_t w;
    wb_xfer(1'b1, addr_of(tile_id, index), sel, dat, ack, err, rd);
    if (!ack || err) report_fail($sformatf("write to index %0d not acked", index));
    w = model[index];
    for (int i = 0; i < tile_pkg::keep_w; i++) begin
      if (sel[i]) w[8*i +: 8] = dat[8*i +: 8];   // Only selected lanes change
    end
    model[index] = w;
  endtask

  task automatic check_read(input int index, input tile_pkg::word_t upper);
    logic            ack;
    logic            err;
    tile_pkg::word_t rd;
    wb_xfer(1'b0, addr_of(tile_id, index) | upper, 4'hf, '0, ack, err, rd);
    if (!ack || err) report_fail($sformatf("read of index %0d not acked", index));
    else if (rd !== model[index])
      report_fail($sformatf("index %0d read %h, expected %h", index, rd, model[index]));
  endtask

  // Header with the start index followed by n data beats
  task automatic mesh_packet(input int start, input int n);
    tile_pkg::word_t w;
    for (int i = 0; i <= n; i++) begin
      w = (i == 0) ? (($urandom << offset_sz) | start) : $urandom;
      noc_in_valid = 1'b1;
      noc_in_data  = w;
      noc_in_last  = (i == n);
      while (!noc_in_ready) begin
        @(posedge clk_line);
        #1;
      end
      @(posedge clk_line);
      #1;
      if (i > 0) begin
        model[(start + i - 1) % depth] = w;    // Wraps within local memory
        mesh_idx.push_back((start + i - 1) % depth);
      end
    end
    noc_in_valid = 1'b0;
  endtask

  // Each beat carries tag, length and beat number and is held until taken
  task automatic offer_packet(input bit on_queue, input int tag, input int len);
    tile_pkg::word_t w;
    tile_pkg::keep_t k;
    for (int i = 0; i < len; i++) begin
      w = (tag << 24) | (len << 16) | i;
      k = (i == len - 1) ? 4'h7 : 4'hf;   // Short last word
      if (on_queue) begin
        queue_valid = 1'b1;
        queue_data  = w;
        queue_keep  = k;
        queue_last  = (i == len - 1);
      end else begin
        fetch_valid = 1'b1;
        fetch_data  = w;
        fetch_keep  = k;
        fetch_last  = (i == len - 1);
      end
      do @(negedge clk_line); while (!(on_queue ? queue_ready : fetch_ready));
      @(posedge clk_line);
      #1;
    end
    if (on_queue) queue_valid = 1'b0;
    else fetch_valid = 1'b0;
  endtask

  // Splits captured beats into packets and checks order, last and keep
  task automatic split_packets(input int beats);
    int tag;
    int len;
    int idx;
    int want;
    want = 0;
    pkt_tags = {};
    if (out_data.size() != beats)
      report_fail($sformatf("%0d beats on mesh output, %0d sent", out_data.size(), beats));
    foreach (out_data[i]) begin
      tag = out_data[i][31:24];
      len = out_data[i][23:16];
      idx = out_data[i][15:0];
      if (want == 0) pkt_tags.push_back(tag);
      else if (tag != pkt_tags[$]) report_fail("packets interleaved on mesh output");
      if (idx != want) report_fail($sformatf("packet %0d beat %0d, expected %0d", tag, idx, want));
      if (out_last[i] !== (want == len - 1) || out_keep[i] !== ((want == len - 1) ? 4'h7 : 4'hf))
        report_fail($sformatf("last or keep wrong on packet %0d beat %0d", tag, idx));
      want = out_last[i] ? 0 : want + 1;
    end
    out_data = {};
    out_last = {};
    out_keep = {};
  endtask

  // ********************
  // Directed tests
  // ********************
  task automatic check_reset_state();
    clk_line_rst_low = 1'b0;
    repeat (2) begin
      @(posedge clk_line);
      #1;
      if (!outputs_low() || noc_in_ready !== 1'b0) report_fail("outputs not low in reset");
    end
    clk_line_rst_low = 1'b1;
    @(posedge clk_line);
    #1;
    if (!outputs_low()) report_fail("outputs not low after reset");
    if (noc_in_ready !== 1'b1) report_fail("noc_in_ready not high after reset");
    end_test("reset state");
  endtask

  task automatic local_access();
    int index;
    for (int p = 0; p < 16; p++) begin
      index = $urandom % depth;
      local_write(index, 4'hf, $urandom);
      local_write(index, p[3:0], $urandom);    // Every lane mask once
      check_read(index, '0);
    end
    check_read(index, 32'h8000_0000);   // Upper address bits ignored
    end_test("local access");
  endtask

  task automatic remote_access();
    logic            ack;
    logic            err;
    tile_pkg::word_t rd;
    int              index;
    index = $urandom % depth;
    local_write(index, 4'hf, $urandom);
    wb_xfer(1'b1, addr_of(tile_id ^ 6'h09, index), 4'hf, ~model[index], ack, err, rd);
    if (ack || !err) report_fail("remote write did not end in an error");
    wb_xfer(1'b0, addr_of(tile_id ^ 6'h20, index), 4'hf, '0, ack, err, rd);
    if (ack || !err) report_fail("remote read did not end in an error");
    check_read(index, '0);
    end_test("remote access");
  endtask

  task automatic mesh_writes();
    mesh_idx = {};
    repeat (4) mesh_packet($urandom % depth, 1 + $urandom % 5);
    mesh_packet(mesh_idx[0], 0);    // Header only
    mesh_packet(depth - 2, 4);      // Runs past the top of memory
    foreach (mesh_idx[i]) check_read(mesh_idx[i], '0);
    end_test("mesh writes");
  endtask

  task automatic egress_priority();
    ready_mode = 1;
    fork
      offer_packet(1'b0, 1, 3);
      offer_packet(1'b1, 2, 2);
    join
    fork
      offer_packet(1'b1, 3, 4);
      begin
        repeat (2) @(posedge clk_line);
        #1;
        offer_packet(1'b0, 4, 2);    // Arrives while queue owns the output
      end
    join
    split_packets(11);
    if (pkt_tags.size() != 4) report_fail("wrong packet count in priority test");
    foreach (pkt_tags[i]) begin
      if (pkt_tags[i] != i + 1) report_fail($sformatf("packet %0d out of order", pkt_tags[i]));
    end
    end_test("egress priority");
  endtask

  task automatic back_pressure();
    int last_f;
    int last_q;
    ready_mode = 2;
    last_f = 9;
    last_q = 19;
    fork
      for (int p = 0; p < 4; p++) offer_packet(1'b0, 10 + p, 1 + p);
      for (int p = 0; p < 4; p++) offer_packet(1'b1, 20 + p, 4 - p);
    join
    ready_mode = 0;
    split_packets(20);
    foreach (pkt_tags[i]) begin
      if (pkt_tags[i] < 20 && pkt_tags[i] != last_f + 1) report_fail("fetch packet order");
      if (pkt_tags[i] >= 20 && pkt_tags[i] != last_q + 1) report_fail("queue packet order");
      if (pkt_tags[i] < 20) last_f = pkt_tags[i];
      else last_q = pkt_tags[i];
    end
    end_test("back pressure");
  endtask

  initial begin
    void'($urandom(seed));
    errors = 0;
    tests = 0;
    ready_mode = 0;
    tile_id = 6'h2b;
    clk_line_rst_low = 1'b0;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_sel = '0;
    wb_dat_w = '0;
    noc_in_valid = 1'b0;
    noc_in_data = '0;
    noc_in_last = 1'b0;
    {fetch_valid, fetch_data, fetch_keep, fetch_last} = '0;
    {queue_valid, queue_data, queue_keep, queue_last} = '0;
    noc_out_ready = 1'b0;
    check_reset_state();
    local_access();
    remote_access();
    mesh_writes();
    egress_priority();
    back_pressure();
    $display("Tests run %0d, failed checks %0d", tests, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/tile_mem_hub.sv
`timescale 1ns/10ps
`default_nettype none

module tile_mem_hub #(
  parameter int offset_sz = tile_pkg::default_offset_sz,
  parameter int xy_sz     = tile_pkg::default_xy_sz
) (
  input  wire                   clk_line,
  input  wire                   clk_line_rst_low,
  input  wire [2*xy_sz-1:0]     tile_id,
  // Wishbone slave
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire tile_pkg::word_t  wb_adr,
  input  wire tile_pkg::keep_t  wb_sel,
  input  wire tile_pkg::word_t  wb_dat_w,
  output tile_pkg::word_t       wb_dat_r,
  output logic                  wb_ack,
  output logic                  wb_err,
  // Mesh input
  input  wire                   noc_in_valid,
  input  wire tile_pkg::word_t  noc_in_data,
  input  wire                   noc_in_last,
  output logic                  noc_in_ready,
  // Fetch stream
  input  wire                   fetch_valid,
  input  wire tile_pkg::word_t  fetch_data,
  input  wire tile_pkg::keep_t  fetch_keep,
  input  wire                   fetch_last,
  output logic                  fetch_ready,
  // Queue stream
  input  wire                   queue_valid,
  input  wire tile_pkg::word_t  queue_data,
  input  wire tile_pkg::keep_t  queue_keep,
  input  wire                   queue_last,
  output logic                  queue_ready,
  // Mesh output
  output logic                  noc_out_valid,
  output tile_pkg::word_t       noc_out_data,
  output tile_pkg::keep_t       noc_out_keep,
  output logic                  noc_out_last,
  input  wire                   noc_out_ready
);

  // Port A, mesh writes
  logic                 a_en;
  logic [offset_sz-1:0] a_index;
  tile_pkg::word_t      a_wdata;

  // Port B, processor
  logic                 b_en;
  tile_pkg::keep_t      b_we;
  logic [offset_sz-1:0] b_index;
  tile_pkg::word_t      b_wdata;
  tile_pkg::word_t      b_rdata;

  proc_mem_port #(
    .offset_sz (offset_sz),
    .xy_sz     (xy_sz)
  ) u_proc_mem_port (
    .clk_line         (clk_line),
    .clk_line_rst_low (clk_line_rst_low),
    .tile_id          (tile_id),
    .wb_cyc           (wb_cyc),
    .wb_stb           (wb_stb),
    .wb_we            (wb_we),
    .wb_adr           (wb_adr),
    .wb_sel           (wb_sel),
    .wb_dat_w         (wb_dat_w),
    .wb_dat_r         (wb_dat_r),
    .wb_ack           (wb_ack),
    .wb_err           (wb_err),
    .b_en             (b_en),
    .b_we             (b_we),
    .b_index          (b_index),
    .b_wdata          (b_wdata),
    .b_rdata          (b_rdata)
  );

  noc_write_port #(
    .offset_sz (offset_sz)
  ) u_noc_write_port (
    .clk_line         (clk_line),
    .clk_line_rst_low (clk_line_rst_low),
    .noc_in_valid     (noc_in_valid),
    .noc_in_data      (noc_in_data),
    .noc_in_last      (noc_in_last),
    .noc_in_ready     (noc_in_ready),
    .a_en             (a_en),
    .a_index          (a_index),
    .a_wdata          (a_wdata)
  );

  data_ram #(
    .offset_sz (offset_sz)
  ) u_data_ram (
    .clk_line (clk_line),
    .a_en     (a_en),
    .a_index  (a_index),
    .a_wdata  (a_wdata),
    .b_en     (b_en),
    .b_we     (b_we),
    .b_index  (b_index),
    .b_wdata  (b_wdata),
    .b_rdata  (b_rdata)
  );

  egress_arbiter u_egress_arbiter (
    .clk_line         (clk_line),
    .clk_line_rst_low (clk_line_rst_low),
    .fetch_valid      (fetch_valid),
    .fetch_data       (fetch_data),
    .fetch_keep       (fetch_keep),
    .fetch_last       (fetch_last),
    .fetch_ready      (fetch_ready),
    .queue_valid      (queue_valid),
    .queue_data       (queue_data),
    .queue_keep       (queue_keep),
    .queue_last       (queue_last),
    .queue_ready      (queue_ready),
    .noc_out_valid    (noc_out_valid),
    .noc_out_data     (noc_out_data),
    .noc_out_keep     (noc_out_keep),
    .noc_out_last     (noc_out_last),
    .noc_out_ready    (noc_out_ready)
  );

endmodule

`default_nettype wire

// File: logic/egress_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module egress_arbiter (
  input  wire                   clk_line,
  input  wire                   clk_line_rst_low,
  // Instruction-fetch producer
  input  wire                   fetch_valid,
  input  wire tile_pkg::word_t  fetch_data,
  input  wire tile_pkg::keep_t  fetch_keep,
  input  wire                   fetch_last,
  output logic                  fetch_ready,
  // Queue producer
  input  wire                   queue_valid,
  input  wire tile_pkg::word_t  queue_data,
  input  wire tile_pkg::keep_t  queue_keep,
  input  wire                   queue_last,
  output logic                  queue_ready,
  // Mesh output
  output logic                  noc_out_valid,
  output tile_pkg::word_t       noc_out_data,
  output tile_pkg::keep_t       noc_out_keep,
  output logic                  noc_out_last,
  input  wire                   noc_out_ready
);

  logic locked;      // Mid-packet
  logic owner;       // 0 fetch, 1 queue
  logic sel_queue;
  logic xfer;

  // ********************
  // Source select
  // ********************
  // Fixed priority to fetch when idle, owner holds while locked
  always_comb begin
    if (locked) begin
      sel_queue = owner;
    end else begin
      sel_queue = ~fetch_valid;
    end
  end

  // ********************
  // Output steering
  // ********************
  always_comb begin
    if (sel_queue) begin
      noc_out_valid = queue_valid;
      noc_out_data  = queue_data;
      noc_out_keep  = queue_keep;
      noc_out_last  = queue_last;
    end else begin
      noc_out_valid = fetch_valid;
      noc_out_data  = fetch_data;
      noc_out_keep  = fetch_keep;
      noc_out_last  = fetch_last;
    end
  end

  // Only the selected source sees the mesh ready
  assign fetch_ready = ~sel_queue & noc_out_ready;
  assign queue_ready = sel_queue & noc_out_ready;

  assign xfer = noc_out_valid & noc_out_ready;

  // ********************
  // Packet lock
  // ********************
  always_ff @(posedge clk_line) begin
    if (!clk_line_rst_low) begin
      locked <= 1'b0;
      owner  <= 1'b0;
    end else if (xfer) begin
      if (noc_out_last) begin
        locked <= 1'b0;          // Packet done, back to idle
      end else begin
        locked <= 1'b1;
        owner  <= sel_queue;     // Same value once locked
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/data_ram.sv
`timescale 1ns/10ps
`default_nettype none

module data_ram #(
  parameter int offset_sz = tile_pkg::default_offset_sz
) (
  input  wire                   clk_line,
  // Port A, mesh side, whole-word writes
  input  wire                   a_en,
  input  wire [offset_sz-1:0]   a_index,
  input  wire tile_pkg::word_t  a_wdata,
  // Port B, processor side, byte lanes and read
  input  wire                   b_en,
  input  wire tile_pkg::keep_t  b_we,
  input  wire [offset_sz-1:0]   b_index,
  input  wire tile_pkg::word_t  b_wdata,
  output tile_pkg::word_t       b_rdata
);

  localparam int depth = 2 ** offset_sz;

  tile_pkg::word_t mem [depth];

  always_ff @(posedge clk_line) begin
    if (a_en) begin
      mem[a_index] <= a_wdata;
    end

    if (b_en) begin
      b_rdata <= mem[b_index];   // Read-first, old contents
      for (int i = 0; i < tile_pkg::keep_w; i++) begin
        if (b_we[i]) begin
          mem[b_index][8*i +: 8] <= b_wdata[8*i +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/noc_write_port.sv
`timescale 1ns/10ps
`default_nettype none

module noc_write_port #(
  parameter int offset_sz = tile_pkg::default_offset_sz
) (
  input  wire                   clk_line,
  input  wire                   clk_line_rst_low,
  // Mesh input stream
  input  wire                   noc_in_valid,
  input  wire tile_pkg::word_t  noc_in_data,
  input  wire                   noc_in_last,
  output logic                  noc_in_ready,
  // Memory port A, write only
  output logic                  a_en,
  output logic [offset_sz-1:0]  a_index,
  output tile_pkg::word_t       a_wdata
);

  logic                 in_data;   // Low while waiting for a header
  logic [offset_sz-1:0] index_q;
  logic                 beat;

  assign beat = noc_in_valid & noc_in_ready;

  // ********************
  // Input flow control
  // ********************
  // No back-pressure once out of reset
  always_ff @(posedge clk_line) begin
    if (!clk_line_rst_low) begin
      noc_in_ready <= 1'b0;
    end else begin
      noc_in_ready <= 1'b1;
    end
  end

  // ********************
  // Header and data tracking
  // ********************
  always_ff @(posedge clk_line) begin
    if (!clk_line_rst_low) begin
      in_data <= 1'b0;
    end else if (beat) begin
      if (!in_data) begin
        in_data <= ~noc_in_last;   // Header-only packet stays in header state
      end else if (noc_in_last) begin
        in_data <= 1'b0;
      end
    end
  end

  // Running word index, wraps within local memory
  always_ff @(posedge clk_line) begin
    if (beat) begin
      if (!in_data) begin
        index_q <= noc_in_data[offset_sz-1:0];   // Start index from header
      end else begin
        index_q <= index_q + 1'b1;
      end
    end
  end

  // Data beat is written in the cycle it moves
  assign a_en    = beat & in_data;
  assign a_index = index_q;
  assign a_wdata = noc_in_data;

endmodule

`default_nettype wire

// File: logic/proc_mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module proc_mem_port #(
  parameter int offset_sz = tile_pkg::default_offset_sz,
  parameter int xy_sz     = tile_pkg::default_xy_sz
) (
  input  wire                   clk_line,
  input  wire                   clk_line_rst_low,
  input  wire [2*xy_sz-1:0]     tile_id,
  // Wishbone classic slave
  input  wire                   wb_cyc,
  input  wire                   wb_stb,
  input  wire                   wb_we,
  input  wire tile_pkg::word_t  wb_adr,      // Byte address
  input  wire tile_pkg::keep_t  wb_sel,
  input  wire tile_pkg::word_t  wb_dat_w,
  output tile_pkg::word_t       wb_dat_r,
  output logic                  wb_ack,
  output logic                  wb_err,
  // Memory port B
  output logic                  b_en,
  output tile_pkg::keep_t       b_we,
  output logic [offset_sz-1:0]  b_index,
  output tile_pkg::word_t       b_wdata,
  input  wire tile_pkg::word_t  b_rdata
);

  logic [2*xy_sz-1:0] tile_field;
  logic               is_local;
  logic               req;

  // Word index is wb_adr >> 2, tile field sits above the local offset
  assign tile_field = wb_adr[2+offset_sz +: 2*xy_sz];
  assign is_local   = (tile_field == tile_id);       // Upper bits ignored

  // New request only when no response is already on the bus
  assign req = wb_cyc & wb_stb & ~(wb_ack | wb_err);

  assign b_en    = req & is_local;
  assign b_we    = wb_we ? wb_sel : '0;
  assign b_index = wb_adr[2 +: offset_sz];
  assign b_wdata = wb_dat_w;

  assign wb_dat_r = b_rdata;  // RAM output is registered, lines up with ack

  always_ff @(posedge clk_line) begin
    if (!clk_line_rst_low) begin
      wb_ack <= 1'b0;
      wb_err <= 1'b0;
    end else begin
      wb_ack <= req & is_local;
      wb_err <= req & ~is_local;   // Other tile, memory untouched
    end
  end

endmodule

`default_nettype wire

// File: logic/tile_pkg.sv
`default_nettype none

package tile_pkg;

  // ********************
  // Word and lane geometry
  // ********************
  localparam int word_w = 32;           // Memory, bus and stream word
  localparam int keep_w = word_w / 8;   // Byte lanes per word

  typedef logic [word_w-1:0] word_t;
  typedef logic [keep_w-1:0] keep_t;

  // ********************
  // Default tile geometry
  // ********************
  // Word-index bits that reach local memory, 4096 words
  localparam int default_offset_sz = 12;

  // Bits per mesh coordinate, X and Y side by side in the tile id
  localparam int default_xy_sz = 3;

endpackage

`default_nettype wire
